// ==== include/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// datapath and address width
`define CPU_XLEN 32

// r0..r14 in the register file, r15 is the PC
`define CPU_NREGS 16

// first fetch address out of reset
`define CPU_RESET_PC 32'h0800_0000

// flag bits inside the 4-bit nzcv vector
`define CPU_NFB 3
`define CPU_ZFB 2
`define CPU_CFB 1
`define CPU_VFB 0

`endif

// ==== src/cpu_pkg.sv ====
`default_nettype none

`include "cpu_defs.svh"

package cpu_pkg;

	// data-processing opcodes, instr[24:21]
	typedef enum logic [3:0] {
		ALU_AND = 4'b0000,
		ALU_EOR = 4'b0001,
		ALU_SUB = 4'b0010,
		ALU_RSB = 4'b0011,
		ALU_ADD = 4'b0100,
		ALU_ADC = 4'b0101,
		ALU_SBC = 4'b0110,
		ALU_RSC = 4'b0111,
		ALU_TST = 4'b1000,
		ALU_TEQ = 4'b1001,
		ALU_CMP = 4'b1010,
		ALU_CMN = 4'b1011,
		ALU_ORR = 4'b1100,
		ALU_MOV = 4'b1101,
		ALU_BIC = 4'b1110,
		ALU_MVN = 4'b1111
	} alu_op_e;

	typedef enum logic [1:0] {
		KIND_DP   = 2'd0,
		KIND_LS   = 2'd1,
		KIND_BR   = 2'd2,
		KIND_SKIP = 2'd3 // cond failed or not in the subset
	} instr_kind_e;

	typedef enum logic [1:0] {
		SH_LSL = 2'd0,
		SH_LSR = 2'd1,
		SH_ASR = 2'd2,
		SH_ROR = 2'd3
	} shift_e;

	typedef enum logic {
		MS_IDLE,
		MS_ACCESS
	} mem_state_e;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} flags_t;

	typedef struct packed {
		logic [`CPU_XLEN-1:0] instr;
		logic [`CPU_XLEN-1:0] pc;
	} fetch_pkt_t;

	typedef struct packed {
		instr_kind_e          kind;
		alu_op_e              op;
		logic [3:0]           rd;
		logic [3:0]           rn;
		logic                 s;
		logic                 l;
		logic                 p;
		logic                 u;
		logic                 w;
		logic [`CPU_XLEN-1:0] rn_val;
		logic [`CPU_XLEN-1:0] st_data;
		logic [`CPU_XLEN-1:0] operand; // before the shifter
		shift_e               sh_type;
		logic [4:0]           sh_amt;
		logic                 imm;     // rotated 8-bit immediate
		logic [23:0]          br_off;
		logic                 link;
		logic [`CPU_XLEN-1:0] pc;
	} dec_pkt_t;

	typedef struct packed {
		instr_kind_e          kind;
		logic [`CPU_XLEN-1:0] result;
		logic                 we;
		logic [3:0]           rd;
		flags_t               flags;
		logic                 flags_en;
		logic [`CPU_XLEN-1:0] addr;
		logic [`CPU_XLEN-1:0] wb_val;
		logic                 wb_en;
		logic [3:0]           rn;
		logic [`CPU_XLEN-1:0] st_data;
		logic                 l;
		logic [`CPU_XLEN-1:0] next_pc;
	} ex_pkt_t;

	typedef struct packed {
		logic [`CPU_XLEN-1:0] addr;
		logic [`CPU_XLEN-1:0] wdata;
		logic                 rd;
		logic                 wr;
	} mem_req_t;

	typedef struct packed {
		logic                 we0;
		logic [3:0]           idx0;
		logic [`CPU_XLEN-1:0] val0;
		logic                 we1;
		logic [3:0]           idx1;
		logic [`CPU_XLEN-1:0] val1;
		flags_t               flags;
		logic                 flags_en;
		logic [`CPU_XLEN-1:0] next_pc;
	} retire_t;

endpackage

`default_nettype wire

// ==== src/fetch_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module fetch_stage (
	input  logic                 clk,
	input  logic                 rstn,
	input  logic                 i_retire,
	input  cpu_pkg::retire_t     i_retire_rec,
	output cpu_pkg::mem_req_t    o_fetch_req,
	input  logic [`CPU_XLEN-1:0] i_rdata,
	input  logic                 i_ok,
	output logic                 o_valid,
	output cpu_pkg::fetch_pkt_t  o_pkt
);

	logic [`CPU_XLEN-1:0] pc;
	logic busy;
	logic kick; // high through reset, starts the first fetch

	always_ff @(posedge clk) begin
		if (!rstn) begin
			pc <= `CPU_RESET_PC;
			busy <= 1'b0;
			kick <= 1'b1;
			o_valid <= 1'b0;
		end else begin
			kick <= 1'b0;
			o_valid <= busy & i_ok;
			if (i_retire)
				pc <= i_retire_rec.next_pc;
			if (kick | i_retire)
				busy <= 1'b1;
			else if (i_ok)
				busy <= 1'b0; // word arrives this cycle
		end
	end

	// instruction word and its address
	always_ff @(posedge clk) begin
		if (busy & i_ok)
			o_pkt <= '{instr: i_rdata, pc: pc};
	end

	assign o_fetch_req = '{addr: pc, wdata: '0, rd: busy, wr: 1'b0};

endmodule

`default_nettype wire

// ==== src/decode_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module decode_stage (
	input  logic                 clk,
	input  logic                 rstn,
	input  logic                 i_valid,
	input  cpu_pkg::fetch_pkt_t  i_pkt,
	output logic [3:0]           o_rd_addr_a,
	output logic [3:0]           o_rd_addr_b,
	input  logic [`CPU_XLEN-1:0] i_rd_data_a,
	input  logic [`CPU_XLEN-1:0] i_rd_data_b,
	input  cpu_pkg::flags_t      i_flags,
	output logic                 o_valid,
	output cpu_pkg::dec_pkt_t    o_pkt
);

	logic [`CPU_XLEN-1:0] instr;
	logic [`CPU_XLEN-1:0] pc8;
	logic [`CPU_XLEN-1:0] val_a;
	logic [`CPU_XLEN-1:0] val_b;
	logic [3:0] fv;
	logic [3:0] addr_a;
	logic [3:0] addr_b;
	logic cond_base;
	logic cond_ok;
	logic is_dp;
	logic is_ls;
	logic is_br;
	cpu_pkg::instr_kind_e kind;
	cpu_pkg::dec_pkt_t pkt;

	assign instr = i_pkt.instr;
	assign fv = i_flags;

	// even codes test, odd codes invert; 1111 never passes
	always_comb begin
		case (instr[31:29])
			3'd0: cond_base = fv[`CPU_ZFB];
			3'd1: cond_base = fv[`CPU_CFB];
			3'd2: cond_base = fv[`CPU_NFB];
			3'd3: cond_base = fv[`CPU_VFB];
			3'd4: cond_base = fv[`CPU_CFB] & ~fv[`CPU_ZFB];
			3'd5: cond_base = fv[`CPU_NFB] == fv[`CPU_VFB];
			3'd6: cond_base = ~fv[`CPU_ZFB] & (fv[`CPU_NFB] == fv[`CPU_VFB]);
			default: cond_base = 1'b1;
		endcase
	end
	assign cond_ok = cond_base ^ instr[28];

	// reg-shift, multiply and MRS/MSR space excluded
	assign is_dp = (instr[27:26] == 2'b00) && !(!instr[25] && instr[4])
		&& !(instr[24:23] == 2'b10 && !instr[20]);
	assign is_ls = (instr[27:25] == 3'b010) && !instr[22]; // word, imm offset only
	assign is_br = (instr[27:25] == 3'b101);

	always_comb begin
		if (!cond_ok)
			kind = cpu_pkg::KIND_SKIP;
		else if (is_dp)
			kind = cpu_pkg::KIND_DP;
		else if (is_ls)
			kind = cpu_pkg::KIND_LS;
		else if (is_br)
			kind = cpu_pkg::KIND_BR;
		else
			kind = cpu_pkg::KIND_SKIP;
	end

	assign addr_a = instr[19:16];
	assign addr_b = is_ls ? instr[15:12] : instr[3:0]; // store data or rm
	assign o_rd_addr_a = addr_a;
	assign o_rd_addr_b = addr_b;

	assign pc8 = i_pkt.pc + 32'd8;
	assign val_a = (addr_a == 4'hf) ? pc8 : i_rd_data_a;
	assign val_b = (addr_b == 4'hf) ? pc8 : i_rd_data_b;

	always_comb begin
		pkt.kind = kind;
		pkt.op = cpu_pkg::alu_op_e'(instr[24:21]);
		pkt.rd = instr[15:12];
		pkt.rn = instr[19:16];
		pkt.s = instr[20];
		pkt.l = instr[20];
		pkt.p = instr[24];
		pkt.u = instr[23];
		pkt.w = instr[21];
		pkt.rn_val = val_a;
		pkt.st_data = val_b;
		pkt.br_off = instr[23:0];
		pkt.link = instr[24];
		pkt.pc = i_pkt.pc;
		if (is_ls) begin
			pkt.imm = 1'b1;
			pkt.operand = {20'b0, instr[11:0]};
			pkt.sh_type = cpu_pkg::SH_LSL;
			pkt.sh_amt = 5'd0;
		end else if (instr[25]) begin
			pkt.imm = 1'b1;
			pkt.operand = {24'b0, instr[7:0]};
			pkt.sh_type = cpu_pkg::SH_ROR;
			pkt.sh_amt = {instr[11:8], 1'b0}; // twice the rotate field
		end else begin
			pkt.imm = 1'b0;
			pkt.operand = val_b;
			pkt.sh_type = cpu_pkg::shift_e'(instr[6:5]);
			pkt.sh_amt = instr[11:7];
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn)
			o_valid <= 1'b0;
		else
			o_valid <= i_valid;
	end

	always_ff @(posedge clk) begin
		if (i_valid)
			o_pkt <= pkt;
	end

endmodule

`default_nettype wire

// ==== src/exec_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module exec_stage (
	input  logic              clk,
	input  logic              rstn,
	input  logic              i_valid,
	input  cpu_pkg::dec_pkt_t i_pkt,
	input  cpu_pkg::flags_t   i_flags,
	output logic              o_valid,
	output cpu_pkg::ex_pkt_t  o_pkt
);

	logic [`CPU_XLEN-1:0] opnd;
	logic [`CPU_XLEN-1:0] rot_val;
	logic [`CPU_XLEN-1:0] sh_val;
	logic [`CPU_XLEN-1:0] a;
	logic [`CPU_XLEN-1:0] x;
	logic [`CPU_XLEN-1:0] y;
	logic [`CPU_XLEN-1:0] res;
	logic [`CPU_XLEN-1:0] ls_sum;
	logic [`CPU_XLEN-1:0] br_target;
	logic [`CPU_XLEN:0] ext;
	logic [`CPU_XLEN:0] sum;
	logic [4:0] amt;
	logic sh_carry;
	logic cin;
	logic arith;
	cpu_pkg::flags_t alu_flags;
	cpu_pkg::ex_pkt_t pkt;

	assign opnd = i_pkt.operand;
	assign amt = i_pkt.sh_amt;
	assign rot_val = (opnd >> amt) | (opnd << (6'd32 - {1'b0, amt}));

	// barrel shifter, amount 0 has the special meanings of mode 1
	always_comb begin
		ext = '0;
		sh_val = opnd;
		sh_carry = i_flags.c;
		if (i_pkt.imm) begin
			sh_val = rot_val;
			if (amt != 5'd0)
				sh_carry = rot_val[31];
		end else begin
			case (i_pkt.sh_type)
				cpu_pkg::SH_LSL: begin
					ext = {1'b0, opnd} << amt;
					sh_val = ext[31:0];
					if (amt != 5'd0)
						sh_carry = ext[32];
				end
				cpu_pkg::SH_LSR: begin
					ext = {opnd, 1'b0} >> amt;
					sh_val = (amt == 5'd0) ? '0 : ext[32:1]; // lsr #32
					sh_carry = (amt == 5'd0) ? opnd[31] : ext[0];
				end
				cpu_pkg::SH_ASR: begin
					ext = $signed({opnd, 1'b0}) >>> amt;
					sh_val = (amt == 5'd0) ? {32{opnd[31]}} : ext[32:1];
					sh_carry = (amt == 5'd0) ? opnd[31] : ext[0];
				end
				default: begin
					// ror #0 is rrx
					sh_val = (amt == 5'd0) ? {i_flags.c, opnd[31:1]} : rot_val;
					sh_carry = (amt == 5'd0) ? opnd[0] : rot_val[31];
				end
			endcase
		end
	end

	assign a = i_pkt.rn_val;

	always_comb begin
		x = a;
		y = sh_val;
		cin = 1'b0;
		arith = 1'b1;
		res = '0;
		case (i_pkt.op)
			cpu_pkg::ALU_SUB, cpu_pkg::ALU_CMP: begin
				y = ~sh_val;
				cin = 1'b1;
			end
			cpu_pkg::ALU_RSB: begin
				x = sh_val;
				y = ~a;
				cin = 1'b1;
			end
			cpu_pkg::ALU_ADC: cin = i_flags.c;
			cpu_pkg::ALU_SBC: begin
				y = ~sh_val;
				cin = i_flags.c;
			end
			cpu_pkg::ALU_RSC: begin
				x = sh_val;
				y = ~a;
				cin = i_flags.c;
			end
			cpu_pkg::ALU_ADD, cpu_pkg::ALU_CMN: cin = 1'b0;
			default: arith = 1'b0;
		endcase
		sum = {1'b0, x} + {1'b0, y} + {32'b0, cin};
		case (i_pkt.op)
			cpu_pkg::ALU_AND, cpu_pkg::ALU_TST: res = a & sh_val;
			cpu_pkg::ALU_EOR, cpu_pkg::ALU_TEQ: res = a ^ sh_val;
			cpu_pkg::ALU_ORR: res = a | sh_val;
			cpu_pkg::ALU_MOV: res = sh_val;
			cpu_pkg::ALU_BIC: res = a & ~sh_val;
			cpu_pkg::ALU_MVN: res = ~sh_val;
			default: res = sum[31:0];
		endcase
		alu_flags.n = res[31];
		alu_flags.z = (res == '0);
		alu_flags.c = arith ? sum[32] : sh_carry;
		alu_flags.v = arith ? ((x[31] == y[31]) && (sum[31] != x[31])) : i_flags.v;
	end

	assign ls_sum = i_pkt.u ? (a + opnd) : (a - opnd);
	assign br_target = i_pkt.pc + 32'd8 + {{6{i_pkt.br_off[23]}}, i_pkt.br_off, 2'b00};

	always_comb begin
		pkt.kind = i_pkt.kind;
		pkt.result = res;
		pkt.we = 1'b0;
		pkt.rd = i_pkt.rd;
		pkt.flags = alu_flags;
		pkt.flags_en = 1'b0;
		pkt.addr = i_pkt.p ? ls_sum : a; // post-index uses the old base
		pkt.wb_val = ls_sum;
		pkt.wb_en = 1'b0;
		pkt.rn = i_pkt.rn;
		pkt.st_data = i_pkt.st_data;
		pkt.l = i_pkt.l;
		pkt.next_pc = i_pkt.pc + 32'd4;
		case (i_pkt.kind)
			cpu_pkg::KIND_DP: begin
				pkt.we = (i_pkt.op[3:2] != 2'b10); // compares set flags only
				pkt.flags_en = i_pkt.s;
				if (pkt.we && i_pkt.rd == 4'hf)
					pkt.next_pc = res;
			end
			cpu_pkg::KIND_LS: pkt.wb_en = !i_pkt.p || i_pkt.w;
			cpu_pkg::KIND_BR: begin
				pkt.we = i_pkt.link;
				pkt.rd = 4'd14;
				pkt.result = i_pkt.pc + 32'd4; // link value
				pkt.next_pc = br_target;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn)
			o_valid <= 1'b0;
		else
			o_valid <= i_valid;
	end

	always_ff @(posedge clk) begin
		if (i_valid)
			o_pkt <= pkt;
	end

endmodule

`default_nettype wire

// ==== src/mem_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module mem_stage (
	input  logic                 clk,
	input  logic                 rstn,
	input  logic                 i_valid,
	input  cpu_pkg::ex_pkt_t     i_pkt,
	input  cpu_pkg::mem_req_t    i_fetch_req,
	output logic [`CPU_XLEN-1:0] o_fetch_rdata,
	output logic                 o_fetch_ok,
	output logic [`CPU_XLEN-1:0] o_mem_addr,
	output logic [`CPU_XLEN-1:0] o_mem_wdata,
	input  logic [`CPU_XLEN-1:0] i_mem_rdata,
	output logic                 o_mem_read,
	output logic                 o_mem_write,
	input  logic                 i_mem_ok,
	output logic                 o_retire,
	output cpu_pkg::retire_t     o_retire_rec
);

	cpu_pkg::mem_state_e state;
	cpu_pkg::mem_req_t data_req;
	cpu_pkg::mem_req_t bus_req;
	cpu_pkg::retire_t rec;
	logic is_ls;
	logic access;
	logic take;

	assign is_ls = (i_pkt.kind == cpu_pkg::KIND_LS);
	assign access = (state == cpu_pkg::MS_ACCESS);

	// exec output is held, so the request stays stable until ok
	assign data_req = '{addr: i_pkt.addr, wdata: i_pkt.st_data, rd: i_pkt.l, wr: !i_pkt.l};
	assign bus_req = access ? data_req : i_fetch_req;

	assign o_mem_addr = bus_req.addr;
	assign o_mem_wdata = bus_req.wdata;
	assign o_mem_read = bus_req.rd;
	assign o_mem_write = bus_req.wr;

	assign o_fetch_rdata = i_mem_rdata;
	assign o_fetch_ok = i_mem_ok & ~access;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= cpu_pkg::MS_IDLE;
			o_retire <= 1'b0;
		end else begin
			o_retire <= take;
			case (state)
				cpu_pkg::MS_IDLE:
					if (i_valid && is_ls)
						state <= cpu_pkg::MS_ACCESS;
				default:
					if (i_mem_ok)
						state <= cpu_pkg::MS_IDLE;
			endcase
		end
	end

	assign take = (!access && i_valid && !is_ls) || (access && i_mem_ok);

	// port 0 is rd, port 1 the base writeback
	always_comb begin
		rec.we0 = i_pkt.we;
		rec.idx0 = i_pkt.rd;
		rec.val0 = i_pkt.result;
		rec.we1 = 1'b0;
		rec.idx1 = i_pkt.rn;
		rec.val1 = i_pkt.wb_val;
		rec.flags = i_pkt.flags;
		rec.flags_en = i_pkt.flags_en;
		rec.next_pc = i_pkt.next_pc;
		if (is_ls) begin
			rec.we0 = i_pkt.l;
			rec.val0 = i_mem_rdata;
			rec.we1 = i_pkt.wb_en;
			if (i_pkt.l && i_pkt.rd == 4'hf)
				rec.next_pc = i_mem_rdata; // ldr pc
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			o_retire_rec <= rec;
	end

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module reg_file (
	input  logic                 clk,
	input  logic                 rstn,
	input  logic [3:0]           i_rd_addr_a,
	input  logic [3:0]           i_rd_addr_b,
	output logic [`CPU_XLEN-1:0] o_rd_data_a,
	output logic [`CPU_XLEN-1:0] o_rd_data_b,
	input  logic                 i_retire,
	input  cpu_pkg::retire_t     i_retire_rec,
	output cpu_pkg::flags_t      o_flags
);

	// r0..r14 only, decode supplies r15
	logic [`CPU_XLEN-1:0] regs [0:`CPU_NREGS-2];

	assign o_rd_data_a = (i_rd_addr_a == 4'hf) ? '0 : regs[i_rd_addr_a];
	assign o_rd_data_b = (i_rd_addr_b == 4'hf) ? '0 : regs[i_rd_addr_b];

	always_ff @(posedge clk) begin
		if (i_retire) begin
			if (i_retire_rec.we1 && i_retire_rec.idx1 != 4'hf)
				regs[i_retire_rec.idx1] <= i_retire_rec.val1;
			// loaded value wins over writeback to the same register
			if (i_retire_rec.we0 && i_retire_rec.idx0 != 4'hf)
				regs[i_retire_rec.idx0] <= i_retire_rec.val0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn)
			o_flags <= '0;
		else if (i_retire && i_retire_rec.flags_en)
			o_flags <= i_retire_rec.flags;
	end

endmodule

`default_nettype wire

// ==== src/cpu_core.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_core (
	input  logic                 clk,
	input  logic                 rstn,
	output logic [`CPU_XLEN-1:0] o_mem_addr,
	output logic [`CPU_XLEN-1:0] o_mem_wdata,
	input  logic [`CPU_XLEN-1:0] i_mem_rdata,
	output logic                 o_mem_read,
	output logic                 o_mem_write,
	input  logic                 i_mem_ok
);

	cpu_pkg::mem_req_t fetch_req;
	cpu_pkg::fetch_pkt_t fetch_pkt;
	cpu_pkg::dec_pkt_t dec_pkt;
	cpu_pkg::ex_pkt_t ex_pkt;
	cpu_pkg::retire_t retire_rec;
	cpu_pkg::flags_t flags;
	logic [`CPU_XLEN-1:0] fetch_rdata;
	logic [`CPU_XLEN-1:0] rd_data_a;
	logic [`CPU_XLEN-1:0] rd_data_b;
	logic [3:0] rd_addr_a;
	logic [3:0] rd_addr_b;
	logic fetch_ok;
	logic fetch_valid;
	logic dec_valid;
	logic ex_valid;
	logic retire;

	fetch_stage u_fetch (
		.clk(clk), .rstn(rstn),
		.i_retire(retire), .i_retire_rec(retire_rec),
		.o_fetch_req(fetch_req), .i_rdata(fetch_rdata), .i_ok(fetch_ok),
		.o_valid(fetch_valid), .o_pkt(fetch_pkt)
	);

	decode_stage u_decode (
		.clk(clk), .rstn(rstn),
		.i_valid(fetch_valid), .i_pkt(fetch_pkt),
		.o_rd_addr_a(rd_addr_a), .o_rd_addr_b(rd_addr_b),
		.i_rd_data_a(rd_data_a), .i_rd_data_b(rd_data_b), .i_flags(flags),
		.o_valid(dec_valid), .o_pkt(dec_pkt)
	);

	exec_stage u_exec (
		.clk(clk), .rstn(rstn),
		.i_valid(dec_valid), .i_pkt(dec_pkt), .i_flags(flags),
		.o_valid(ex_valid), .o_pkt(ex_pkt)
	);

	mem_stage u_mem (
		.clk(clk), .rstn(rstn),
		.i_valid(ex_valid), .i_pkt(ex_pkt), .i_fetch_req(fetch_req),
		.o_fetch_rdata(fetch_rdata), .o_fetch_ok(fetch_ok),
		.o_mem_addr(o_mem_addr), .o_mem_wdata(o_mem_wdata), .i_mem_rdata(i_mem_rdata),
		.o_mem_read(o_mem_read), .o_mem_write(o_mem_write), .i_mem_ok(i_mem_ok),
		.o_retire(retire), .o_retire_rec(retire_rec)
	);

	reg_file u_regs (
		.clk(clk), .rstn(rstn),
		.i_rd_addr_a(rd_addr_a), .i_rd_addr_b(rd_addr_b),
		.o_rd_data_a(rd_data_a), .o_rd_data_b(rd_data_b),
		.i_retire(retire), .i_retire_rec(retire_rec), .o_flags(flags)
	);

endmodule

`default_nettype wire

// ==== test/cpu_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_properties (
	input logic                 clk,
	input logic                 rstn,
	input logic                 o_mem_read,
	input logic                 o_mem_write,
	input logic                 i_mem_ok,
	input logic [`CPU_XLEN-1:0] o_mem_addr,
	input logic [`CPU_XLEN-1:0] o_mem_wdata
);

	one_strobe: assert property (@(posedge clk) disable iff (!rstn)
		!(o_mem_read && o_mem_write))
		else $error("bus read and write high in the same cycle");

	// request holds until the memory answers
	read_hold: assert property (@(posedge clk) disable iff (!rstn)
		(o_mem_read && !i_mem_ok) |=> (o_mem_read && $stable(o_mem_addr)))
		else $error("read request changed before ok");

	write_hold: assert property (@(posedge clk) disable iff (!rstn)
		(o_mem_write && !i_mem_ok)
		|=> (o_mem_write && $stable(o_mem_addr) && $stable(o_mem_wdata)))
		else $error("write request changed before ok");

	reset_quiet: assert property (@(posedge clk)
		(!rstn && $past(!rstn)) |-> (!o_mem_read && !o_mem_write))
		else $error("bus strobe high during reset");

endmodule

bind mem_stage cpu_properties u_props (
	.clk(clk), .rstn(rstn),
	.o_mem_read(o_mem_read), .o_mem_write(o_mem_write), .i_mem_ok(i_mem_ok),
	.o_mem_addr(o_mem_addr), .o_mem_wdata(o_mem_wdata)
);

`default_nettype wire

// ==== test/cpu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_tb;

	logic clk;
	logic rstn;
	logic [`CPU_XLEN-1:0] o_mem_addr;
	logic [`CPU_XLEN-1:0] o_mem_wdata;
	logic [`CPU_XLEN-1:0] i_mem_rdata;
	logic o_mem_read;
	logic o_mem_write;
	logic i_mem_ok;

	logic [31:0] mem [0:4095];     // 16 KB at the reset PC
	logic [31:0] ref_mem [0:4095];
	logic [31:0] prog [0:1023];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [31:0] lcg_state;
	logic [31:0] halt_addr;
	int prog_len;
	int obs_idx;
	int errors;
	int model_steps;
	int cyc;
	int watchdog_limit;
	int wcnt;
	int tests_run;
	int tests_failed;
	bit zero_wait;
	bit halted;
	bit running;
	bit active;
	bit first_seen;

	cpu_core i_cpu_core (
		.clk(clk), .rstn(rstn),
		.o_mem_addr(o_mem_addr), .o_mem_wdata(o_mem_wdata), .i_mem_rdata(i_mem_rdata),
		.o_mem_read(o_mem_read), .o_mem_write(o_mem_write), .i_mem_ok(i_mem_ok)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return addr ^ {addr[15:0], addr[31:16]} ^ 32'h3c5a_96e1;
	endfunction

	function automatic int word_index(input logic [31:0] addr);
		return int'(addr[13:2]);
	endfunction

	function automatic logic [31:0] dp_imm(input logic [3:0] cond, input logic [3:0] op,
		input logic s, input logic [3:0] rn, input logic [3:0] rd,
		input logic [3:0] rot, input logic [7:0] imm8);
		return {cond, 3'b001, op, s, rn, rd, rot, imm8};
	endfunction

	function automatic logic [31:0] dp_reg(input logic [3:0] cond, input logic [3:0] op,
		input logic s, input logic [3:0] rn, input logic [3:0] rd,
		input logic [4:0] amt, input logic [1:0] sh, input logic [3:0] rm);
		return {cond, 3'b000, op, s, rn, rd, amt, sh, 1'b0, rm};
	endfunction

	function automatic logic [31:0] ls_imm(input logic p, input logic u, input logic w,
		input logic l, input logic [3:0] rn, input logic [3:0] rd, input logic [11:0] off);
		return {4'he, 3'b010, p, u, 1'b0, w, l, rn, rd, off};
	endfunction

	function automatic logic [31:0] branch(input logic [3:0] cond, input logic l,
		input logic [23:0] off);
		return {cond, 3'b101, l, off};
	endfunction

	task automatic emit(input logic [31:0] word);
		prog[prog_len] = word;
		prog_len++;
	endtask

	// post-indexed store through the r13 pointer
	task automatic store_reg(input logic [3:0] rd);
		emit(ls_imm(1'b0, 1'b1, 1'b0, 1'b0, 4'd13, rd, 12'd4));
	endtask

	task automatic load_const(input logic [3:0] rd, input logic [31:0] v);
		emit(dp_imm(4'he, 4'hd, 1'b0, 4'd0, rd, 4'd0, v[7:0]));
		emit(dp_imm(4'he, 4'hc, 1'b0, rd, rd, 4'd12, v[15:8]));
		emit(dp_imm(4'he, 4'hc, 1'b0, rd, rd, 4'd8, v[23:16]));
		emit(dp_imm(4'he, 4'hc, 1'b0, rd, rd, 4'd4, v[31:24]));
	endtask

	// nzcv gathered in r3 by conditional orr and stored
	task automatic capture_flags();
		emit(dp_imm(4'he, 4'hd, 1'b0, 4'd0, 4'd3, 4'd0, 8'd0));
		emit(dp_imm(4'h4, 4'hc, 1'b0, 4'd3, 4'd3, 4'd0, 8'd8));
		emit(dp_imm(4'h0, 4'hc, 1'b0, 4'd3, 4'd3, 4'd0, 8'd4));
		emit(dp_imm(4'h2, 4'hc, 1'b0, 4'd3, 4'd3, 4'd0, 8'd2));
		emit(dp_imm(4'h6, 4'hc, 1'b0, 4'd3, 4'd3, 4'd0, 8'd1));
		store_reg(4'd3);
	endtask

	task automatic build_program();
		prog_len = 0;
		load_const(4'd13, 32'h0800_1000);
		for (int v = 0; v < 2; v++) begin
			for (int op = 0; op < 16; op++) begin
				lcg_state = lcg_next(lcg_state);
				load_const(4'd0, lcg_state);
				lcg_state = lcg_next(lcg_state);
				load_const(4'd1, lcg_state ^ {lcg_state[15:0], 16'h0});
				lcg_state = lcg_next(lcg_state);
				if (v == 0)
					emit(dp_imm(4'he, op[3:0], 1'b1, 4'd0, 4'd2, lcg_state[27:24],
						lcg_state[23:16]));
				else
					emit(dp_reg(4'he, op[3:0], 1'b1, 4'd0, 4'd2,
						(op < 4) ? 5'd0 : lcg_state[20:16], op[1:0], 4'd1));
				store_reg(4'd2);
				capture_flags();
			end
		end
		// loads and stores with both index modes
		load_const(4'd6, 32'h0800_2000);
		emit(ls_imm(1'b1, 1'b1, 1'b1, 1'b0, 4'd13, 4'd0, 12'd4));
		emit(ls_imm(1'b1, 1'b0, 1'b0, 1'b1, 4'd13, 4'd4, 12'd4));
		emit(ls_imm(1'b1, 1'b1, 1'b0, 1'b1, 4'd13, 4'd5, 12'd0));
		emit(ls_imm(1'b0, 1'b0, 1'b0, 1'b1, 4'd6, 4'd7, 12'd8));
		emit(ls_imm(1'b1, 1'b1, 1'b1, 1'b1, 4'd6, 4'd8, 12'd12));
		store_reg(4'd4);
		store_reg(4'd5);
		store_reg(4'd7);
		store_reg(4'd8);
		store_reg(4'd6);
		store_reg(4'd13);
		// bne falls through after cmp r0,r0
		emit(dp_reg(4'he, 4'ha, 1'b1, 4'd0, 4'd0, 5'd0, 2'd0, 4'd0));
		emit(branch(4'h1, 1'b0, 24'd0));
		store_reg(4'd0);
		emit(branch(4'he, 1'b0, 24'd0));
		store_reg(4'd1); // jumped over
		store_reg(4'd2);
		emit(branch(4'he, 1'b0, 24'd1));
		store_reg(4'd14); // subroutine
		emit(dp_reg(4'he, 4'hd, 1'b0, 4'd0, 4'd15, 5'd0, 2'd0, 4'd14));
		emit(branch(4'he, 1'b1, 24'hff_fffc));
		halt_addr = `CPU_RESET_PC + 32'(prog_len * 4);
		emit(branch(4'he, 1'b0, 24'hff_fffe));
	endtask

	task automatic load_memory();
		for (int i = 0; i < 4096; i++)
			mem[i] = (i < prog_len) ? prog[i] : fill_word(`CPU_RESET_PC + 32'(i * 4));
	endtask

	function automatic logic cond_pass(input logic [3:0] cc, input logic n, input logic z,
		input logic c, input logic v);
		case (cc)
			4'd0: return z;
			4'd1: return !z;
			4'd2: return c;
			4'd3: return !c;
			4'd4: return n;
			4'd5: return !n;
			4'd6: return v;
			4'd7: return !v;
			4'd8: return c && !z;
			4'd9: return !c || z;
			4'd10: return n == v;
			4'd11: return n != v;
			4'd12: return !z && (n == v);
			4'd13: return z || (n != v);
			4'd14: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// {carry, value} of the mode 1 shifter operand
	function automatic logic [32:0] shifter(input logic [31:0] ins, input logic [31:0] rm,
		input logic cf);
		logic [31:0] val;
		logic [4:0] amt;
		int r;
		if (ins[25]) begin
			r = int'(ins[11:8]) * 2;
			val = ({24'b0, ins[7:0]} >> r) | ({24'b0, ins[7:0]} << (32 - r));
			return {(r == 0) ? cf : val[31], val};
		end
		amt = ins[11:7];
		case (ins[6:5])
			2'd0: return (amt == 0) ? {cf, rm} : {rm[32 - amt], rm << amt};
			2'd1: return (amt == 0) ? {rm[31], 32'b0} : {rm[amt - 1], rm >> amt};
			2'd2: return (amt == 0) ? {rm[31], {32{rm[31]}}}
				: {rm[amt - 1], 32'($signed(rm) >>> amt)};
			default: return (amt == 0) ? {rm[0], cf, rm[31:1]}
				: {rm[amt - 1], (rm >> amt) | (rm << (32 - amt))};
		endcase
	endfunction

	function automatic void alu_model(input logic [3:0] op, input logic [31:0] a,
		input logic [31:0] b, input logic cf, input logic vf, input logic sc,
		output logic [31:0] res, output logic co, output logic vo);
		logic [32:0] t;
		co = sc;
		vo = vf;
		case (op)
			4'h0, 4'h8: res = a & b;
			4'h1, 4'h9: res = a ^ b;
			4'hc: res = a | b;
			4'hd: res = b;
			4'he: res = a & ~b;
			4'hf: res = ~b;
			4'h4, 4'h5, 4'hb: begin
				t = {1'b0, a} + {1'b0, b} + ((op == 4'h5) ? 33'(cf) : 33'd0);
				res = t[31:0];
				co = t[32];
				vo = (a[31] == b[31]) && (res[31] != a[31]);
			end
			4'h3, 4'h7: begin
				t = {1'b0, b} - {1'b0, a} - ((op == 4'h7) ? 33'(!cf) : 33'd0);
				res = t[31:0];
				co = !t[32]; // no borrow
				vo = (a[31] != b[31]) && (res[31] != b[31]);
			end
			default: begin
				t = {1'b0, a} - {1'b0, b} - ((op == 4'h6) ? 33'(!cf) : 33'd0);
				res = t[31:0];
				co = !t[32];
				vo = (a[31] != b[31]) && (res[31] != a[31]);
			end
		endcase
	endfunction

	// ISA model of the subset fills the expected store list
	function automatic void run_model();
		logic [31:0] r [0:15];
		logic [31:0] pc, ins, a, b, res, sum, ad, data, sdata;
		logic [32:0] so;
		logic n, z, c, v, co, vo;
		int steps;
		for (int i = 0; i < 16; i++)
			r[i] = '0;
		for (int i = 0; i < 4096; i++)
			ref_mem[i] = mem[i];
		{n, z, c, v} = 4'b0;
		pc = `CPU_RESET_PC;
		exp_addr.delete();
		exp_data.delete();
		steps = 0;
		while (steps < 5000 && pc != halt_addr) begin
			ins = ref_mem[word_index(pc)];
			steps++;
			r[15] = pc + 32'd8;
			if (!cond_pass(ins[31:28], n, z, c, v)) begin
				pc = pc + 4;
			end else if (ins[27:26] == 2'b00) begin
				a = r[ins[19:16]];
				so = shifter(ins, r[ins[3:0]], c);
				alu_model(ins[24:21], a, so[31:0], c, v, so[32], res, co, vo);
				if (ins[20])
					{n, z, c, v} = {res[31], res == 0, co, vo};
				pc = pc + 4;
				if (ins[24:23] != 2'b10) begin
					if (ins[15:12] == 4'd15)
						pc = res;
					else
						r[ins[15:12]] = res;
				end
			end else if (ins[27:25] == 3'b010) begin
				a = r[ins[19:16]];
				sum = ins[23] ? a + {20'b0, ins[11:0]} : a - {20'b0, ins[11:0]};
				ad = ins[24] ? sum : a;
				sdata = r[ins[15:12]];
				data = ref_mem[word_index(ad)];
				pc = pc + 4;
				if (!ins[24] || ins[21])
					r[ins[19:16]] = sum;
				if (ins[20]) begin
					if (ins[15:12] == 4'd15)
						pc = data;
					else
						r[ins[15:12]] = data;
				end else begin
					exp_addr.push_back(ad);
					exp_data.push_back(sdata);
					ref_mem[word_index(ad)] = sdata;
				end
			end else if (ins[27:25] == 3'b101) begin
				if (ins[24])
					r[14] = pc + 4;
				pc = pc + 8 + {{6{ins[23]}}, ins[23:0], 2'b00};
			end else begin
				pc = pc + 4;
			end
		end
		model_steps = steps + 1;
	endfunction

	// memory model answers 1ns after the edge
	always @(posedge clk) begin
		#1;
		if (!rstn || i_mem_ok) begin
			i_mem_ok = 1'b0;
			active = 1'b0;
		end else if (o_mem_read || o_mem_write) begin
			if (!active) begin
				active = 1'b1;
				lcg_state = lcg_next(lcg_state);
				wcnt = zero_wait ? 0 : int'(lcg_state[17:16]);
			end
			if (wcnt == 0) begin
				i_mem_ok = 1'b1;
				if (o_mem_addr[31:14] != `CPU_RESET_PC >> 14) begin
					errors++;
					$display("bus access at %h is outside the memory", o_mem_addr);
				end else if (o_mem_read) begin
					i_mem_rdata = mem[word_index(o_mem_addr)];
					if (o_mem_addr == halt_addr)
						halted = 1'b1;
				end else begin
					mem[word_index(o_mem_addr)] = o_mem_wdata;
				end
			end else begin
				wcnt--;
			end
		end
	end

	// compare observed bus traffic against the model
	always @(posedge clk) begin
		if (rstn && running) begin
			if (!first_seen && (o_mem_read || o_mem_write)) begin
				first_seen = 1'b1;
				assert (o_mem_read && !o_mem_write) else begin
					errors++;
					$display("first bus request after reset is not a read");
				end
				assert (o_mem_addr == `CPU_RESET_PC) else begin
					errors++;
					$display("ERROR %0t o_mem_addr got %h expected %h", $time, o_mem_addr,
						`CPU_RESET_PC);
				end
			end
			if (o_mem_write && i_mem_ok) begin
				if (obs_idx >= exp_addr.size()) begin
					errors++;
					$display("store to %h beyond the expected list", o_mem_addr);
				end else begin
					assert (o_mem_addr == exp_addr[obs_idx]) else begin
						errors++;
						$display("ERROR %0t o_mem_addr got %h expected %h", $time,
							o_mem_addr, exp_addr[obs_idx]);
					end
					assert (o_mem_wdata == exp_data[obs_idx]) else begin
						errors++;
						$display("ERROR %0t o_mem_wdata got %h expected %h", $time,
							o_mem_wdata, exp_data[obs_idx]);
					end
				end
				obs_idx++;
			end
		end
	end

	// watchdog limit follows the model's instruction count
	always @(posedge clk) begin
		if (running) begin
			cyc++;
			if (cyc > watchdog_limit) begin
				$display("timeout: the program never reached its final branch");
				$display("Finished with errors");
				$finish;
			end
		end
	end

	task automatic run_program(input bit zw, input string name);
		int err_before;
		err_before = errors;
		zero_wait = zw;
		load_memory();
		run_model();
		watchdog_limit = model_steps * 20 + 64;
		cyc = 0;
		obs_idx = 0;
		first_seen = 1'b0;
		halted = 1'b0;
		@(posedge clk);
		#1 rstn = 1'b0;
		repeat (16) @(posedge clk);
		#1 rstn = 1'b1;
		running = 1'b1;
		while (!halted)
			@(posedge clk);
		@(posedge clk);
		running = 1'b0;
		if (!first_seen || obs_idx != exp_addr.size()) begin
			errors++;
			$display("%s saw %0d stores, the model expects %0d", name, obs_idx,
				exp_addr.size());
		end
		tests_run++;
		if (errors != err_before)
			tests_failed++;
		$display("test %s: %s, %0d stores", name, (errors == err_before) ? "ok" : "failed",
			obs_idx);
	endtask

	initial begin
		clk = 1'b0;
		rstn = 1'b0;
		i_mem_rdata = '0;
		i_mem_ok = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		running = 1'b0;
		active = 1'b0;
		lcg_state = 32'd46961;
		build_program();
		run_program(1'b1, "zero_wait");
		run_program(1'b0, "random_wait");
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
src/cpu_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/exec_stage.sv
src/mem_stage.sv
src/reg_file.sv
src/cpu_core.sv
test/cpu_properties.sv
test/cpu_tb.sv

// ==== Makefile ====
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -j 0 -f vlog.f \
		--top-module cpu_tb -Mdir obj_dir

run: build
	./obj_dir/Vcpu_tb > sim.log 2>&1; cat sim.log
	grep -qx "Finished with no errors" sim.log

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module cpu_tb
	verilator --lint-only -f vlog.f --top-module cpu_core

clean:
	rm -rf obj_dir sim.log
